//--- cpuTop.f
hw/pipePkg.sv
hw/hazard.sv
hw/memArbiter.sv
hw/unifiedMem.sv
hw/regFile.sv
hw/pipeCore.sv
hw/cpuTop.sv
testbench/cpuTop_props.sv
testbench/cpuTop_tb.sv

//--- hw/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop #(
  parameter int memWords = 1024
) (
  input  wire         clk,
  input  wire         rstN,
  input  wire         run,
  input  wire         loadWe,
  input  wire  [15:0] loadAddr,
  input  wire  [31:0] loadData,
  output logic [31:0] loadRdata,
  output logic        wbValid,
  output logic [3:0]  wbReg,
  output logic [31:0] wbData,
  output logic        halted
);

  pipePkg::busReq_t   loadReq;
  pipePkg::busReq_t   dataReq;
  pipePkg::busReq_t   fetchReq;
  pipePkg::busReq_t   memReq;
  pipePkg::hazardIn_t  hzIn;
  pipePkg::hazardOut_t hzOut;
  logic [31:0] memRdata;
  logic [31:0] dataRdata;
  logic [31:0] fetchData;

  // Loader owns the bus whenever the core is stopped
  assign loadReq = '{valid: !run, write: loadWe, addr: loadAddr, wdata: loadData};

  pipeCore u_pipeCore (
    .clk       (clk),
    .rstN      (rstN),
    .run       (run),
    .fetchReq  (fetchReq),
    .fetchData (fetchData),
    .dataReq   (dataReq),
    .dataRdata (dataRdata),
    .hzIn      (hzIn),
    .hzOut     (hzOut),
    .wbValid   (wbValid),
    .wbReg     (wbReg),
    .wbData    (wbData),
    .halted    (halted)
  );

  hazard u_hazard (
    .clk   (clk),
    .rstN  (rstN),
    .hzIn  (hzIn),
    .hzOut (hzOut)
  );

  memArbiter u_memArbiter (
    .loadReq   (loadReq),
    .dataReq   (dataReq),
    .fetchReq  (fetchReq),
    .memReq    (memReq),
    .memRdata  (memRdata),
    .loadRdata (loadRdata),
    .dataRdata (dataRdata),
    .fetchData (fetchData)
  );

  unifiedMem #(
    .memWords (memWords)
  ) u_unifiedMem (
    .clk      (clk),
    .memReq   (memReq),
    .memRdata (memRdata)
  );

endmodule

`default_nettype wire

//--- hw/hazard.sv
`timescale 1ns/10ps
`default_nettype none

module hazard (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire pipePkg::hazardIn_t hzIn,
  output pipePkg::hazardOut_t     hzOut
);

  // Consumer in decode reads the load now in execute
  logic loadUse;
  // Memory stage owns the bus this cycle, fetch is refused
  logic fetchConflict;

  assign loadUse = (hzIn.match1DE | hzIn.match2DE) & hzIn.memToRegE;
  assign fetchConflict = hzIn.memBusyM;

  always_comb begin
    // Newest producer first, memory stage beats writeback
    if (hzIn.match1EM && hzIn.regWriteM) begin
      hzOut.forwardAE = pipePkg::fwdMem;
    end else if (hzIn.match1EW && hzIn.regWriteW) begin
      hzOut.forwardAE = pipePkg::fwdWb;
    end else begin
      hzOut.forwardAE = pipePkg::fwdNone;
    end

    // Same priority for the second source
    if (hzIn.match2EM && hzIn.regWriteM) begin
      hzOut.forwardBE = pipePkg::fwdMem;
    end else if (hzIn.match2EW && hzIn.regWriteW) begin
      hzOut.forwardBE = pipePkg::fwdWb;
    end else begin
      hzOut.forwardBE = pipePkg::fwdNone;
    end

    // Decode holds for load-use, a lost fetch or a decoded HALT
    hzOut.stallD = loadUse | fetchConflict | hzIn.haltD;
    // Fetch holds whenever decode does
    hzOut.stallF = hzOut.stallD;

    // Bubble into execute behind a load, or squash the wrong path
    hzOut.flushE = loadUse | hzIn.branchTakenE;
    // A refused fetch delivers no word, so decode gets a NOP
    // Load-use keeps the decode instruction instead
    hzOut.flushD = hzIn.branchTakenE | (fetchConflict & ~loadUse);
  end

endmodule

`default_nettype wire

//--- hw/memArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module memArbiter (
  input  wire pipePkg::busReq_t loadReq,
  input  wire pipePkg::busReq_t dataReq,
  input  wire pipePkg::busReq_t fetchReq,
  output pipePkg::busReq_t      memReq,
  input  wire [31:0]            memRdata,
  output logic [31:0]           loadRdata,
  output logic [31:0]           dataRdata,
  output logic [31:0]           fetchData
);

  // Fixed priority, loader then data port then fetch
  // Loader is only valid while the core is not running
  // Fetch loses silently, the core sees that through memBusyM
  always_comb begin
    loadRdata = '0;
    dataRdata = '0;
    fetchData = '0;

    if (loadReq.valid) begin
      memReq = loadReq;
      loadRdata = memRdata;
    end else if (dataReq.valid) begin
      memReq = dataReq;
      dataRdata = memRdata;
    end else begin
      // Fetch owns the bus by default
      memReq = fetchReq;
      fetchData = memRdata;
    end
  end

endmodule

`default_nettype wire

//--- hw/pipeCore.sv
`timescale 1ns/10ps
`default_nettype none

module pipeCore (
  input  wire                      clk,
  input  wire                      rstN,
  input  wire                      run,
  output pipePkg::busReq_t         fetchReq,
  input  wire [31:0]               fetchData,
  output pipePkg::busReq_t         dataReq,
  input  wire [31:0]               dataRdata,
  output pipePkg::hazardIn_t       hzIn,
  input  wire pipePkg::hazardOut_t hzOut,
  output logic                     wbValid,
  output logic [3:0]               wbReg,
  output logic [31:0]              wbData,
  output logic                     halted
);

  pipePkg::decodeReg_t    dReg;
  pipePkg::executeReg_t   eReg;
  pipePkg::memoryReg_t    mReg;
  pipePkg::writebackReg_t wReg;

  logic [15:0] pc;
  logic [15:0] branchTarget;
  logic [31:0] rfData1;
  logic [31:0] rfData2;
  logic [31:0] srcA;
  logic [31:0] srcB;
  logic [31:0] immExt;
  logic [31:0] aluOut;
  logic        memAccess;
  logic        wbWrites;
  logic        haltSeen;

  // Opcodes that retire a register write
  function automatic logic writesReg(input pipePkg::opcode_t op);
    return op == pipePkg::ADD || op == pipePkg::SUB ||
           op == pipePkg::ADDI || op == pipePkg::LDR;
  endfunction

  // Fetch stage
  always_comb begin
    fetchReq.valid = run && !hzOut.stallF;
    fetchReq.write = 1'b0;
    fetchReq.addr  = pc;
    fetchReq.wdata = '0;
  end

  // PC sits at zero until run, a taken branch overrides the fetch stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (!run) begin
      pc <= '0;
    end else if (hzIn.branchTakenE) begin
      pc <= branchTarget;
    end else if (!hzOut.stallF) begin
      pc <= pc + 16'd1;
    end
  end

  // Decode register, flush has priority over stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dReg <= '0;
    end else if (!run || hzOut.flushD) begin
      dReg <= '0;
    end else if (!hzOut.stallD) begin
      dReg.instr <= pipePkg::instr_t'(fetchData);
      dReg.pc    <= pc;
    end
  end

  // Decode stage register reads
  regFile u_regFile (
    .clk    (clk),
    .rstN   (rstN),
    .raddr1 (dReg.instr.rn),
    .raddr2 (dReg.instr.rm),
    .rdata1 (rfData1),
    .rdata2 (rfData2),
    .we     (wbWrites),
    .waddr  (wReg.rd),
    .wdata  (wReg.result)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      eReg <= '0;
    end else if (hzOut.flushE) begin
      eReg <= '0;
    end else begin
      eReg.instr <= dReg.instr;
      eReg.pc    <= dReg.pc;
      eReg.srcA  <= rfData1;
      eReg.srcB  <= rfData2;
    end
  end

  // Execute operand muxes
  always_comb begin
    case (hzOut.forwardAE)
      pipePkg::fwdMem: srcA = mReg.aluOut;
      pipePkg::fwdWb:  srcA = wReg.result;
      default:         srcA = eReg.srcA;
    endcase
    case (hzOut.forwardBE)
      pipePkg::fwdMem: srcB = mReg.aluOut;
      pipePkg::fwdWb:  srcB = wReg.result;
      default:         srcB = eReg.srcB;
    endcase
  end

  assign immExt = {{16{eReg.instr.imm16[15]}}, eReg.instr.imm16};

  // ALU, immediate form also gives the LDR and STR address
  always_comb begin
    case (eReg.instr.opcode)
      pipePkg::ADD: aluOut = srcA + srcB;
      pipePkg::SUB: aluOut = srcA - srcB;
      default:      aluOut = srcA + immExt;
    endcase
  end

  // Branches are unconditional
  assign branchTarget = eReg.pc + 16'd1 + eReg.instr.imm16;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mReg <= '0;
    end else begin
      mReg.opcode    <= eReg.instr.opcode;
      mReg.rd        <= eReg.instr.rd;
      mReg.aluOut    <= aluOut;
      mReg.storeData <= srcB;
    end
  end

  // Memory stage on the data port
  assign memAccess = mReg.opcode == pipePkg::LDR || mReg.opcode == pipePkg::STR;

  always_comb begin
    dataReq.valid = memAccess;
    dataReq.write = mReg.opcode == pipePkg::STR;
    dataReq.addr  = mReg.aluOut[15:0];
    dataReq.wdata = mReg.storeData;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wReg <= '0;
    end else begin
      wReg.opcode <= mReg.opcode;
      wReg.rd     <= mReg.rd;
      wReg.result <= (mReg.opcode == pipePkg::LDR) ? dataRdata : mReg.aluOut;
    end
  end

  // Retire trace
  assign wbWrites = writesReg(wReg.opcode);
  assign wbValid  = wbWrites;
  assign wbReg    = wReg.rd;
  assign wbData   = wReg.result;

  // Sticky once HALT has been in writeback
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      haltSeen <= 1'b0;
    end else if (wReg.opcode == pipePkg::HALT) begin
      haltSeen <= 1'b1;
    end
  end

  assign halted = haltSeen || wReg.opcode == pipePkg::HALT;

  // Register matches and stage status for the hazard unit
  always_comb begin
    hzIn.match1EM     = eReg.instr.rn == mReg.rd;
    hzIn.match1EW     = eReg.instr.rn == wReg.rd;
    hzIn.match2EM     = eReg.instr.rm == mReg.rd;
    hzIn.match2EW     = eReg.instr.rm == wReg.rd;
    hzIn.match1DE     = dReg.instr.rn == eReg.instr.rd;
    hzIn.match2DE     = dReg.instr.rm == eReg.instr.rd;
    hzIn.regWriteM    = writesReg(mReg.opcode);
    hzIn.regWriteW    = wbWrites;
    hzIn.memToRegE    = eReg.instr.opcode == pipePkg::LDR;
    hzIn.branchTakenE = eReg.instr.opcode == pipePkg::B;
    // A HALT past decode keeps fetch frozen even after a refused fetch
    hzIn.haltD        = dReg.instr.opcode == pipePkg::HALT ||
                        eReg.instr.opcode == pipePkg::HALT ||
                        mReg.opcode == pipePkg::HALT || halted;
    hzIn.memBusyM     = memAccess;
  end

endmodule

`default_nettype wire

//--- hw/pipePkg.sv
`default_nettype none

package pipePkg;

  // Zero is NOP so a cleared stage register is a bubble
  typedef enum logic [3:0] {
    NOP  = 4'h0,
    ADD  = 4'h1,
    SUB  = 4'h2,
    ADDI = 4'h3,
    LDR  = 4'h4,
    STR  = 4'h5,
    B    = 4'h6,
    HALT = 4'h7
  } opcode_t;

  // ADD and SUB combine rn with rm, ADDI adds imm16 to rn
  // LDR and STR address rn + imm16, STR stores rm
  // B jumps to pc + 1 + imm16
  typedef struct packed {
    opcode_t     opcode;
    logic [3:0]  rd;
    logic [3:0]  rn;
    logic [3:0]  rm;
    logic [15:0] imm16;
  } instr_t;

  // One request per bus peer, word addressed
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [15:0] addr;
    logic [31:0] wdata;
  } busReq_t;

  // Execute operand source
  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } fwdSel_t;

  // Core status seen by the hazard unit
  typedef struct packed {
    logic match1EM, match1EW, match2EM, match2EW, match1DE, match2DE;
    logic regWriteM, regWriteW, memToRegE, branchTakenE, haltD, memBusyM;
  } hazardIn_t;

  typedef struct packed {
    fwdSel_t forwardAE;
    fwdSel_t forwardBE;
    logic    stallF, stallD, flushD, flushE;
  } hazardOut_t;

  // Fetch to decode
  typedef struct packed {
    instr_t      instr;
    logic [15:0] pc;
  } decodeReg_t;

  // Decode to execute, operands as read from the register file
  typedef struct packed {
    instr_t      instr;
    logic [15:0] pc;
    logic [31:0] srcA, srcB;
  } executeReg_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [3:0]  rd;
    logic [31:0] aluOut, storeData;
  } memoryReg_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [3:0]  rd;
    logic [31:0] result;
  } writebackReg_t;

endpackage

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  wire         clk,
  input  wire         rstN,
  input  wire  [3:0]  raddr1,
  input  wire  [3:0]  raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  wire         we,
  input  wire  [3:0]  waddr,
  input  wire  [31:0] wdata
);

  logic [31:0] regs [16];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Writeback value reaches decode in the same cycle
  assign rdata1 = (we && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

//--- hw/unifiedMem.sv
`timescale 1ns/10ps
`default_nettype none

module unifiedMem #(
  parameter int memWords = 1024
) (
  input  wire                   clk,
  input  wire pipePkg::busReq_t memReq,
  output logic [31:0]           memRdata
);

  localparam int addrBits = $clog2(memWords);

  // Shared instruction and data words
  logic [31:0] mem [memWords];
  logic [addrBits-1:0] wordAddr;

  // Upper address bits beyond the array are ignored
  assign wordAddr = memReq.addr[addrBits-1:0];

  // Read in the same cycle
  assign memRdata = mem[wordAddr];

  always_ff @(posedge clk) begin
    if (memReq.valid && memReq.write) begin
      mem[wordAddr] <= memReq.wdata;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTop_tb -f cpuTop.f \
  && ./obj_dir/VcpuTop_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && exit 0 || exit 1

//--- testbench/cpuTop_props.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop_props (
  input wire                      clk,
  input wire                      rstN,
  input wire pipePkg::hazardIn_t  hzIn,
  input wire pipePkg::hazardOut_t hzOut
);

  // Select encoding 11 has no source
  fwdLegal: assert property (@(posedge clk) disable iff (!rstN)
    hzOut.forwardAE != 2'b11 && hzOut.forwardBE != 2'b11)
    else $error("forwarding select 11 seen");

  // Decode never holds while fetch runs on
  stallOrder: assert property (@(posedge clk) disable iff (!rstN)
    hzOut.stallD |-> hzOut.stallF)
    else $error("stallD without stallF");

  // A lone taken branch squashes, it does not stall
  branchFlushOnly: assert property (@(posedge clk) disable iff (!rstN)
    (hzIn.branchTakenE && !hzIn.memBusyM && !hzIn.haltD) |->
      !(hzOut.flushE && hzOut.stallD))
    else $error("branch set flushE and stallD together");

endmodule

bind hazard cpuTop_props u_cpuTopProps (
  .clk   (clk),
  .rstN  (rstN),
  .hzIn  (hzIn),
  .hzOut (hzOut)
);

`default_nettype wire

//--- testbench/cpuTop_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop_tb;

  localparam int imgWords = 128;
  localparam int haltTimeout = 2000;

  logic        clk;
  logic        rstN;
  logic        run;
  logic        loadWe;
  logic [15:0] loadAddr;
  logic [31:0] loadData;
  logic [31:0] loadRdata;
  logic        wbValid;
  logic [3:0]  wbReg;
  logic [31:0] wbData;
  logic        halted;

  // Program and data image, plus the reference model's copy
  logic [31:0] memInit [imgWords];
  logic [31:0] memModel [imgWords];
  logic [31:0] regModel [16];
  int          progLen;
  int          errors;
  int          checks;
  logic [31:0] lfsr;

  // Expected and observed register writes
  logic [3:0]  expReg [$];
  logic [31:0] expData [$];
  logic [3:0]  gotReg [$];
  logic [31:0] gotData [$];

  cpuTop #(
    .memWords (1024)
  ) u_cpuTop (
    .clk       (clk),
    .rstN      (rstN),
    .run       (run),
    .loadWe    (loadWe),
    .loadAddr  (loadAddr),
    .loadData  (loadData),
    .loadRdata (loadRdata),
    .wbValid   (wbValid),
    .wbReg     (wbReg),
    .wbData    (wbData),
    .halted    (halted)
  );

  always #2 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsrBits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic void checkValue(input string what, input logic [31:0] got,
                                     input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got %h expected %h", what, got, exp);
    end
  endfunction

  // Stray ADDI in every word, rd and imm16 taken from the address
  // Anything fetched past HALT would retire a visible write
  function automatic void fillImage();
    pipePkg::instr_t fill;
    for (int i = 0; i < imgWords; i++) begin
      fill = '{opcode: pipePkg::ADDI, rd: 4'(i), rn: 4'd0, rm: 4'd0, imm16: 16'(i)};
      memInit[i] = fill;
    end
    progLen = 0;
  endfunction

  // Append one instruction word to the program
  function automatic void emit(input pipePkg::opcode_t op, input logic [3:0] rd,
                               input logic [3:0] rn, input logic [3:0] rm,
                               input logic [15:0] imm);
    pipePkg::instr_t instr;
    instr = '{opcode: op, rd: rd, rn: rn, rm: rm, imm16: imm};
    memInit[progLen] = instr;
    progLen++;
  endfunction

  function automatic void writeModel(input logic [3:0] rd, input logic [31:0] value);
    regModel[rd] = value;
    expReg.push_back(rd);
    expData.push_back(value);
  endfunction

  // Sequential ISA model, one instruction per step
  function automatic void runModel(input string name);
    pipePkg::instr_t instr;
    logic [15:0]     pc;
    logic [31:0]     imm;
    logic [31:0]     addr;
    logic            done;
    int              steps;
    pc = '0;
    done = 1'b0;
    steps = 0;
    expReg.delete();
    expData.delete();
    for (int i = 0; i < imgWords; i++) begin
      memModel[i] = memInit[i];
    end
    for (int i = 0; i < 16; i++) begin
      regModel[i] = '0;
    end
    while (!done && steps < 1000) begin
      instr = pipePkg::instr_t'(memModel[pc[6:0]]);
      imm = {{16{instr.imm16[15]}}, instr.imm16};
      addr = regModel[instr.rn] + imm;
      // Branch offsets count from the next word
      pc = pc + 16'd1;
      steps++;
      case (instr.opcode)
        pipePkg::ADD:  writeModel(instr.rd, regModel[instr.rn] + regModel[instr.rm]);
        pipePkg::SUB:  writeModel(instr.rd, regModel[instr.rn] - regModel[instr.rm]);
        pipePkg::ADDI: writeModel(instr.rd, regModel[instr.rn] + imm);
        pipePkg::LDR:  writeModel(instr.rd, memModel[addr[6:0]]);
        pipePkg::STR:  memModel[addr[6:0]] = regModel[instr.rm];
        pipePkg::B:    pc = pc + instr.imm16;
        pipePkg::HALT: done = 1'b1;
        default:       ;
      endcase
    end
    assert (done) else begin
      errors++;
      $display("%s: reference model never reached HALT", name);
    end
  endfunction

  // Reset held for three cycles, outputs must be quiet afterwards
  task automatic resetDut();
    @(posedge clk);
    rstN <= 1'b0;
    run <= 1'b0;
    loadWe <= 1'b0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkValue("wbValid after reset", 32'(wbValid), 32'd0);
    checkValue("halted after reset", 32'(halted), 32'd0);
  endtask

  // Loader owns the bus while run is low
  task automatic loadImage();
    for (int i = 0; i < imgWords; i++) begin
      @(posedge clk);
      loadWe <= 1'b1;
      loadAddr <= 16'(i);
      loadData <= memInit[i];
    end
    @(posedge clk);
    loadWe <= 1'b0;
  endtask

  task automatic runAndCollect(input string name);
    int cycles;
    gotReg.delete();
    gotData.delete();
    cycles = 0;
    @(posedge clk);
    run <= 1'b1;
    do begin
      @(negedge clk);
      if (wbValid) begin
        gotReg.push_back(wbReg);
        gotData.push_back(wbData);
      end
      cycles++;
    end while (!halted && cycles < haltTimeout);
    assert (halted) else begin
      errors++;
      $display("%s: timed out waiting for halted", name);
    end
    // Halt is sticky and nothing retires behind it
    repeat (20) begin
      @(negedge clk);
      assert (halted && !wbValid) else begin
        errors++;
        $display("%s: halted dropped or a write retired after halt", name);
      end
    end
  endtask

  task automatic compareTrace(input string name);
    checkValue($sformatf("%s retire count", name), 32'(gotReg.size()), 32'(expReg.size()));
    for (int i = 0; i < expReg.size() && i < gotReg.size(); i++) begin
      checkValue($sformatf("%s wbReg[%0d]", name, i), 32'(gotReg[i]), 32'(expReg[i]));
      checkValue($sformatf("%s wbData[%0d]", name, i), gotData[i], expData[i]);
    end
  endtask

  // Read back the whole image through the loader port
  task automatic checkMemory(input string name);
    @(posedge clk);
    run <= 1'b0;
    for (int i = 0; i < imgWords; i++) begin
      @(posedge clk);
      loadAddr <= 16'(i);
      @(negedge clk);
      checkValue($sformatf("%s loadRdata[%0d]", name, i), loadRdata, memModel[i]);
    end
  endtask

  task automatic runProgram(input string name);
    runModel(name);
    resetDut();
    loadImage();
    runAndCollect(name);
    compareTrace(name);
    checkMemory(name);
  endtask

  task automatic independentOps();
    fillImage();
    for (int r = 1; r <= 6; r++) begin
      emit(pipePkg::ADDI, 4'(r), 4'd0, 4'd0, 16'(lfsrBits(16)));
    end
    emit(pipePkg::ADD, 4'd7, 4'd1, 4'd2, 16'd0);
    emit(pipePkg::SUB, 4'd8, 4'd3, 4'd4, 16'd0);
    emit(pipePkg::ADD, 4'd9, 4'd5, 4'd6, 16'd0);
    emit(pipePkg::HALT, 4'd0, 4'd0, 4'd0, 16'd0);
    runProgram("independent");
  endtask

  task automatic forwardingChains();
    fillImage();
    emit(pipePkg::ADDI, 4'd1, 4'd0, 4'd0, 16'(lfsrBits(16)));
    // Operand straight from the memory stage
    emit(pipePkg::ADDI, 4'd1, 4'd1, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::ADD, 4'd2, 4'd1, 4'd1, 16'd0);
    // r2 from memory, r1 from writeback
    emit(pipePkg::SUB, 4'd3, 4'd2, 4'd1, 16'd0);
    emit(pipePkg::ADDI, 4'd4, 4'd0, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::ADDI, 4'd4, 4'd0, 4'd0, 16'(lfsrBits(16)));
    // Both stages hold r4, the newer value must win
    emit(pipePkg::ADD, 4'd5, 4'd4, 4'd4, 16'd0);
    emit(pipePkg::SUB, 4'd6, 4'd5, 4'd4, 16'd0);
    emit(pipePkg::HALT, 4'd0, 4'd0, 4'd0, 16'd0);
    runProgram("forwarding");
  endtask

  task automatic loadUseStall();
    fillImage();
    for (int i = 64; i < 68; i++) begin
      memInit[i] = lfsrBits(32);
    end
    emit(pipePkg::LDR, 4'd1, 4'd0, 4'd0, 16'd64);
    emit(pipePkg::ADD, 4'd2, 4'd1, 4'd1, 16'd0);
    emit(pipePkg::LDR, 4'd3, 4'd0, 4'd0, 16'd65);
    // Loaded value on the second operand
    emit(pipePkg::SUB, 4'd4, 4'd0, 4'd3, 16'd0);
    emit(pipePkg::ADDI, 4'd6, 4'd0, 4'd0, 16'd60);
    emit(pipePkg::LDR, 4'd5, 4'd6, 4'd0, 16'd6);
    emit(pipePkg::ADDI, 4'd7, 4'd5, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::ADD, 4'd8, 4'd5, 4'd7, 16'd0);
    emit(pipePkg::HALT, 4'd0, 4'd0, 4'd0, 16'd0);
    runProgram("loadUse");
  endtask

  task automatic takenBranch();
    fillImage();
    emit(pipePkg::ADDI, 4'd1, 4'd0, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::B, 4'd0, 4'd0, 4'd0, 16'd2);
    // Two wrong-path words that must never retire
    emit(pipePkg::ADDI, 4'd2, 4'd0, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::ADDI, 4'd3, 4'd0, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::ADDI, 4'd4, 4'd1, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::B, 4'd0, 4'd0, 4'd0, 16'd1);
    emit(pipePkg::ADDI, 4'd5, 4'd0, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::ADD, 4'd6, 4'd4, 4'd1, 16'd0);
    emit(pipePkg::HALT, 4'd0, 4'd0, 4'd0, 16'd0);
    runProgram("branch");
  endtask

  task automatic busSharing();
    fillImage();
    memInit[84] = lfsrBits(32);
    emit(pipePkg::ADDI, 4'd1, 4'd0, 4'd0, 16'd80);
    emit(pipePkg::ADDI, 4'd2, 4'd0, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::STR, 4'd0, 4'd1, 4'd2, 16'd0);
    emit(pipePkg::ADDI, 4'd3, 4'd2, 4'd0, 16'(lfsrBits(16)));
    emit(pipePkg::STR, 4'd0, 4'd1, 4'd3, 16'd1);
    emit(pipePkg::LDR, 4'd4, 4'd1, 4'd0, 16'd0);
    emit(pipePkg::LDR, 4'd5, 4'd1, 4'd0, 16'd1);
    emit(pipePkg::ADD, 4'd6, 4'd4, 4'd5, 16'd0);
    emit(pipePkg::STR, 4'd0, 4'd1, 4'd6, 16'd2);
    emit(pipePkg::SUB, 4'd7, 4'd6, 4'd2, 16'd0);
    emit(pipePkg::STR, 4'd0, 4'd1, 4'd7, 16'd3);
    emit(pipePkg::LDR, 4'd8, 4'd1, 4'd0, 16'd2);
    emit(pipePkg::ADDI, 4'd9, 4'd8, 4'd0, 16'd1);
    emit(pipePkg::LDR, 4'd10, 4'd1, 4'd0, 16'd4);
    emit(pipePkg::STR, 4'd0, 4'd1, 4'd10, 16'd5);
    emit(pipePkg::STR, 4'd0, 4'd1, 4'd9, 16'd6);
    emit(pipePkg::HALT, 4'd0, 4'd0, 4'd0, 16'd0);
    runProgram("busSharing");
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    run = 1'b0;
    loadWe = 1'b0;
    loadAddr = '0;
    loadData = '0;
    errors = 0;
    checks = 0;
    lfsr = 32'h0191_b61a;
    independentOps();
    forwardingChains();
    loadUseStall();
    takenBranch();
    busSharing();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
